// ==== rsp_bank_macros.svh ====
////////////////////////////////////////////////////////////
// Sizes of the response bank, shared by every block.
// RB_ID_W, RB_SLOT_W and RB_LEN_W must agree with the
// counts above them. Nothing checks this at elaboration.
////////////////////////////////////////////////////////////

`ifndef RSP_BANK_MACROS_SVH
`define RSP_BANK_MACROS_SVH

// AXI identifiers
`define RB_NUM_IDS 4
`define RB_ID_W 2

// Slots and burst shape
`define RB_CAPACITY 8
`define RB_SLOT_W 3
`define RB_MAX_BURST 4
`define RB_LEN_W 3

// Beat data without the identifier
`define RB_PAYLOAD_W 16

`endif

// ==== rsp_bank_pkg.sv ====
////////////////////////////////////////////////////////////
// Types shared by the response bank blocks.
// Widths come from the macro header.
////////////////////////////////////////////////////////////

`default_nettype none

`include "rsp_bank_macros.svh"

package rsp_bank_pkg;

  typedef logic [`RB_ID_W-1:0]      rb_id_t;
  typedef logic [`RB_NUM_IDS-1:0]   rb_id_mask_t;
  typedef logic [`RB_SLOT_W-1:0]    rb_slot_t;
  typedef logic [`RB_CAPACITY-1:0]  rb_slot_mask_t;
  typedef logic [`RB_LEN_W-1:0]     rb_len_t;
  typedef logic [`RB_PAYLOAD_W-1:0] rb_payload_t;

  // Data on the input and output ports
  typedef struct packed {rb_id_t id; rb_payload_t payload;} rb_beat_t;

  // One accepted reservation
  typedef struct packed {logic valid; rb_id_t id; rb_slot_t slot; rb_len_t len;} rb_rsv_cmd_t;

  // One accepted input beat
  typedef struct packed {logic valid; rb_id_t id; rb_payload_t payload;} rb_in_cmd_t;

  // Write into the store, beat index only spans the burst
  typedef struct packed {
    logic                              valid;
    rb_slot_t                          slot;
    logic [$clog2(`RB_MAX_BURST)-1:0]  beat;
    rb_payload_t                       payload;
  } rb_wr_cmd_t;

  // Oldest unpopped burst of one identifier
  typedef struct packed {logic ready; rb_slot_t slot; rb_len_t beat; logic last;} rb_tail_t;
  typedef rb_tail_t [`RB_NUM_IDS-1:0] rb_tail_vec_t;

  // One beat loaded into the output register
  typedef struct packed {logic valid; rb_id_t id; logic last;} rb_pop_cmd_t;

endpackage

`default_nettype wire

// ==== rsp_bank_decode.sv ====
////////////////////////////////////////////////////////////
// Handshake decode and free slot search, all combinational.
// clk_i and rst_ni have no loads in this block, so lint
// reports them as unused inputs.
// o_in_ready depends on i_in_valid.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rsp_bank_macros.svh"

module rsp_bank_decode import rsp_bank_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Reservation side
  input  logic          i_rsv_valid,
  input  rb_id_mask_t   i_rsv_id_onehot,
  input  rb_len_t       i_rsv_burst_len,
  output rb_slot_t      o_rsv_addr,
  output logic          o_rsv_ready,
  // Input beats
  input  rb_beat_t      i_in_beat,
  input  logic          i_in_valid,
  output logic          o_in_ready,
  // State from lists and result
  input  rb_slot_mask_t i_slot_busy,
  input  rb_slot_mask_t i_slot_held,
  input  rb_id_mask_t   i_id_pending,
  // Accepted commands
  output rb_rsv_cmd_t   o_rsv_cmd,
  output rb_in_cmd_t    o_in_cmd
);

  rb_slot_mask_t slot_free;
  rb_slot_t      free_slot;
  rb_id_t        rsv_id;

  // A slot whose last beat waits in the output register is not free yet
  assign slot_free = ~(i_slot_busy | i_slot_held);

  // Lowest free slot, scanning down so the lowest hit is kept
  always_comb begin
    free_slot = '0;
    for (int s = `RB_CAPACITY - 1; s >= 0; s--) begin
      if (slot_free[s]) begin
        free_slot = rb_slot_t'(s);
      end
    end
  end

  // One-hot identifier to binary
  always_comb begin
    rsv_id = '0;
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      if (i_rsv_id_onehot[i]) begin
        rsv_id = rb_id_t'(i);
      end
    end
  end

  assign o_rsv_addr  = free_slot;
  assign o_rsv_ready = |slot_free;
  assign o_in_ready  = i_in_valid && i_id_pending[i_in_beat.id];

  // Commands carry the handshake result, so lists never re-checks it
  always_comb begin
    o_rsv_cmd.valid   = i_rsv_valid && o_rsv_ready;
    o_rsv_cmd.id      = rsv_id;
    o_rsv_cmd.slot    = free_slot;
    o_rsv_cmd.len     = i_rsv_burst_len;
    o_in_cmd.valid    = o_in_ready;
    o_in_cmd.id       = i_in_beat.id;
    o_in_cmd.payload  = i_in_beat.payload;
  end

endmodule

`default_nettype wire

// ==== rsp_bank_lists.sv ====
////////////////////////////////////////////////////////////
// Per-identifier linked lists of slots and per-slot beat
// counters. Bursts of one identifier fill and leave in
// reservation order. An input command must target an
// identifier with a pending reservation.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rsp_bank_macros.svh"

module rsp_bank_lists import rsp_bank_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  rb_rsv_cmd_t   i_rsv_cmd,
  input  rb_in_cmd_t    i_in_cmd,
  input  rb_pop_cmd_t   i_pop_cmd,
  output rb_slot_mask_t o_slot_busy,
  output rb_id_mask_t   o_id_pending,
  output rb_tail_vec_t  o_tails,
  output rb_wr_cmd_t    o_wr_cmd
);

  ////////////////////////////////////////////////////////////
  // Per-identifier pointers and burst counts
  ////////////////////////////////////////////////////////////

  // Newest reservation, oldest unfilled burst, oldest unpopped burst
  rb_slot_t rsv_head_q [`RB_NUM_IDS];
  rb_slot_t rsv_head_d [`RB_NUM_IDS];
  rb_slot_t fill_q     [`RB_NUM_IDS];
  rb_slot_t fill_d     [`RB_NUM_IDS];
  rb_slot_t tail_q     [`RB_NUM_IDS];
  rb_slot_t tail_d     [`RB_NUM_IDS];

  // Bursts still waiting for beats, and complete bursts not yet popped
  logic [`RB_SLOT_W:0] n_rsv_q [`RB_NUM_IDS];
  logic [`RB_SLOT_W:0] n_rsv_d [`RB_NUM_IDS];
  logic [`RB_SLOT_W:0] n_cpl_q [`RB_NUM_IDS];
  logic [`RB_SLOT_W:0] n_cpl_d [`RB_NUM_IDS];

  // Slot links, written when a reservation extends a live list
  rb_slot_t nxt_q [`RB_CAPACITY];
  logic     append;

  // Reserved, received and output beats per slot
  rb_len_t rsv_cnt_q [`RB_CAPACITY];
  rb_len_t rcv_cnt_q [`RB_CAPACITY];
  rb_len_t out_cnt_q [`RB_CAPACITY];

  rb_slot_t in_slot;
  rb_slot_t pop_slot;

  assign in_slot  = fill_q[i_in_cmd.id];
  assign pop_slot = tail_q[i_pop_cmd.id];

  always_comb begin : next_state
    logic                rsv_hit;
    logic                in_hit;
    logic                in_done;
    logic                pop_done;
    logic [`RB_SLOT_W:0] rsv_left;
    logic [`RB_SLOT_W:0] cpl_left;
    rb_slot_t            fill_slot;

    append = 1'b0;
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      rsv_hit   = i_rsv_cmd.valid && (i_rsv_cmd.id == rb_id_t'(i));
      in_hit    = i_in_cmd.valid && (i_in_cmd.id == rb_id_t'(i));
      pop_done  = i_pop_cmd.valid && i_pop_cmd.last && (i_pop_cmd.id == rb_id_t'(i));
      fill_slot = fill_q[i];
      // This beat is the last one the burst at the fill pointer waits for
      in_done   = in_hit && (rcv_cnt_q[fill_slot] + 1'b1 == rsv_cnt_q[fill_slot]);

      rsv_left = n_rsv_q[i] - in_done;
      cpl_left = n_cpl_q[i] + in_done - pop_done;
      n_rsv_d[i] = rsv_left + rsv_hit;
      n_cpl_d[i] = cpl_left;

      fill_d[i]     = in_done ? nxt_q[fill_slot] : fill_slot;
      tail_d[i]     = pop_done ? nxt_q[tail_q[i]] : tail_q[i];
      rsv_head_d[i] = rsv_head_q[i];

      if (rsv_hit) begin
        rsv_head_d[i] = i_rsv_cmd.slot;
        // Nothing left to fill, so the new burst is filled next
        if (rsv_left == '0) begin
          fill_d[i] = i_rsv_cmd.slot;
        end
        // Empty list restarts at the new slot, otherwise link it in
        if (rsv_left == '0 && cpl_left == '0) begin
          tail_d[i] = i_rsv_cmd.slot;
        end else begin
          append = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_head_q <= '{default: '0};
      fill_q     <= '{default: '0};
      tail_q     <= '{default: '0};
      n_rsv_q    <= '{default: '0};
      n_cpl_q    <= '{default: '0};
      nxt_q      <= '{default: '0};
    end else begin
      rsv_head_q <= rsv_head_d;
      fill_q     <= fill_d;
      tail_q     <= tail_d;
      n_rsv_q    <= n_rsv_d;
      n_cpl_q    <= n_cpl_d;
      if (append) begin
        nxt_q[rsv_head_q[i_rsv_cmd.id]] <= i_rsv_cmd.slot;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Per-slot beat counters
  ////////////////////////////////////////////////////////////

  // The three commands never address the same slot in one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_cnt_q <= '{default: '0};
      rcv_cnt_q <= '{default: '0};
      out_cnt_q <= '{default: '0};
    end else begin
      if (i_rsv_cmd.valid) begin
        rsv_cnt_q[i_rsv_cmd.slot] <= i_rsv_cmd.len;
        rcv_cnt_q[i_rsv_cmd.slot] <= '0;
        out_cnt_q[i_rsv_cmd.slot] <= '0;
      end
      if (i_in_cmd.valid) begin
        rcv_cnt_q[in_slot] <= rcv_cnt_q[in_slot] + 1'b1;
      end
      if (i_pop_cmd.valid) begin
        if (i_pop_cmd.last) begin
          rsv_cnt_q[pop_slot] <= '0;
          out_cnt_q[pop_slot] <= '0;
        end else begin
          out_cnt_q[pop_slot] <= out_cnt_q[pop_slot] + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < `RB_CAPACITY; s++) begin
      o_slot_busy[s] = rsv_cnt_q[s] != '0;
    end
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      o_id_pending[i]  = n_rsv_q[i] != '0;
      // Complete bursts sit at the front of the list
      o_tails[i].ready = n_cpl_q[i] != '0;
      o_tails[i].slot  = tail_q[i];
      o_tails[i].beat  = out_cnt_q[tail_q[i]];
      o_tails[i].last  = out_cnt_q[tail_q[i]] + 1'b1 == rsv_cnt_q[tail_q[i]];
    end
  end

  always_comb begin
    o_wr_cmd.valid   = i_in_cmd.valid;
    o_wr_cmd.slot    = in_slot;
    o_wr_cmd.beat    = rcv_cnt_q[in_slot][$clog2(`RB_MAX_BURST)-1:0];
    o_wr_cmd.payload = i_in_cmd.payload;
  end

endmodule

`default_nettype wire

// ==== rsp_bank_store.sv ====
////////////////////////////////////////////////////////////
// Payload array, one row of beats per slot.
// One write port, combinational read port.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rsp_bank_macros.svh"

module rsp_bank_store import rsp_bank_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  rb_wr_cmd_t  i_wr_cmd,
  input  rb_slot_t    i_rd_slot,
  input  rb_len_t     i_rd_beat,
  output rb_payload_t o_rd_payload
);

  rb_payload_t mem_q [`RB_CAPACITY][`RB_MAX_BURST];

  // Cleared so reads of unwritten beats return zero, not X
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (i_wr_cmd.valid) begin
      mem_q[i_wr_cmd.slot][i_wr_cmd.beat] <= i_wr_cmd.payload;
    end
  end

  // Beat index never reaches the burst length here
  assign o_rd_payload = mem_q[i_rd_slot][i_rd_beat[$clog2(`RB_MAX_BURST)-1:0]];

endmodule

`default_nettype wire

// ==== rsp_bank_result.sv ====
////////////////////////////////////////////////////////////
// Release arbiter and registered output.
// Lowest identifier with a complete, enabled tail wins.
// Output holds under back-pressure.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rsp_bank_macros.svh"

module rsp_bank_result import rsp_bank_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  rb_tail_vec_t  i_tails,
  input  rb_slot_mask_t i_release_en,
  input  logic          i_out_ready,
  input  rb_payload_t   i_rd_payload,
  output rb_slot_t      o_rd_slot,
  output rb_len_t       o_rd_beat,
  output rb_pop_cmd_t   o_pop_cmd,
  output rb_beat_t      o_out_beat,
  output logic          o_out_valid,
  output rb_slot_mask_t o_released_addr_onehot,
  output rb_slot_mask_t o_slot_held
);

  rb_id_mask_t cand;
  rb_id_t      sel_id;
  logic        sel_valid;
  rb_tail_t    sel_tail;
  logic        load_en;
  logic        out_hs;

  logic        out_valid_q;
  rb_slot_t    out_slot_q;
  logic        out_last_q;
  rb_beat_t    out_beat_q;

  always_comb begin
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      cand[i] = i_tails[i].ready && i_release_en[i_tails[i].slot];
    end
  end

  // Lowest identifier wins
  always_comb begin
    sel_id = '0;
    for (int i = `RB_NUM_IDS - 1; i >= 0; i--) begin
      if (cand[i]) begin
        sel_id = rb_id_t'(i);
      end
    end
  end

  assign sel_valid = |cand;
  assign sel_tail  = i_tails[sel_id];
  assign out_hs    = out_valid_q && i_out_ready;
  // Register empty or draining this cycle
  assign load_en   = !out_valid_q || i_out_ready;

  assign o_rd_slot = sel_tail.slot;
  assign o_rd_beat = sel_tail.beat;

  always_comb begin
    o_pop_cmd.valid = sel_valid && load_en;
    o_pop_cmd.id    = sel_id;
    o_pop_cmd.last  = sel_tail.last;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      out_slot_q  <= '0;
      out_last_q  <= 1'b0;
    end else if (load_en) begin
      out_valid_q <= sel_valid;
      if (sel_valid) begin
        out_slot_q <= sel_tail.slot;
        out_last_q <= sel_tail.last;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_en && sel_valid) begin
      out_beat_q.id      <= sel_id;
      out_beat_q.payload <= i_rd_payload;
    end
  end

  assign o_out_beat  = out_beat_q;
  assign o_out_valid = out_valid_q;

  // Release pulse on the handshake, and hold the slot while its last beat waits
  always_comb begin
    o_released_addr_onehot = '0;
    o_slot_held            = '0;
    if (out_hs) begin
      o_released_addr_onehot[out_slot_q] = 1'b1;
    end
    if (out_valid_q && out_last_q) begin
      o_slot_held[out_slot_q] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rsp_bank.sv ====
////////////////////////////////////////////////////////////
// Response bank top level.
// i_rsv_burst_len must never be zero.
// Reservation id must be one-hot when i_rsv_valid is high.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rsp_bank import rsp_bank_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Reservation
  input  logic          i_rsv_valid,
  input  rb_id_mask_t   i_rsv_id_onehot,
  input  rb_len_t       i_rsv_burst_len,
  output rb_slot_t      o_rsv_addr,
  output logic          o_rsv_ready,
  // Beats from the memory side
  input  rb_beat_t      i_in_beat,
  input  logic          i_in_valid,
  output logic          o_in_ready,
  // Beats to the requester
  output rb_beat_t      o_out_beat,
  output logic          o_out_valid,
  input  logic          i_out_ready,
  // Release control
  input  rb_slot_mask_t i_release_en,
  output rb_slot_mask_t o_released_addr_onehot
);

  rb_rsv_cmd_t   rsv_cmd;
  rb_in_cmd_t    in_cmd;
  rb_wr_cmd_t    wr_cmd;
  rb_pop_cmd_t   pop_cmd;
  rb_tail_vec_t  tails;
  rb_slot_mask_t slot_busy;
  rb_slot_mask_t slot_held;
  rb_id_mask_t   id_pending;
  rb_slot_t      rd_slot;
  rb_len_t       rd_beat;
  rb_payload_t   rd_payload;

  rsp_bank_decode u_decode (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .i_rsv_valid     (i_rsv_valid),
    .i_rsv_id_onehot (i_rsv_id_onehot),
    .i_rsv_burst_len (i_rsv_burst_len),
    .o_rsv_addr      (o_rsv_addr),
    .o_rsv_ready     (o_rsv_ready),
    .i_in_beat       (i_in_beat),
    .i_in_valid      (i_in_valid),
    .o_in_ready      (o_in_ready),
    .i_slot_busy     (slot_busy),
    .i_slot_held     (slot_held),
    .i_id_pending    (id_pending),
    .o_rsv_cmd       (rsv_cmd),
    .o_in_cmd        (in_cmd)
  );

  rsp_bank_lists u_lists (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_rsv_cmd    (rsv_cmd),
    .i_in_cmd     (in_cmd),
    .i_pop_cmd    (pop_cmd),
    .o_slot_busy  (slot_busy),
    .o_id_pending (id_pending),
    .o_tails      (tails),
    .o_wr_cmd     (wr_cmd)
  );

  rsp_bank_store u_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_wr_cmd     (wr_cmd),
    .i_rd_slot    (rd_slot),
    .i_rd_beat    (rd_beat),
    .o_rd_payload (rd_payload)
  );

  rsp_bank_result u_result (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .i_tails                (tails),
    .i_release_en           (i_release_en),
    .i_out_ready            (i_out_ready),
    .i_rd_payload           (rd_payload),
    .o_rd_slot              (rd_slot),
    .o_rd_beat              (rd_beat),
    .o_pop_cmd              (pop_cmd),
    .o_out_beat             (o_out_beat),
    .o_out_valid            (o_out_valid),
    .o_released_addr_onehot (o_released_addr_onehot),
    .o_slot_held            (slot_held)
  );

endmodule

`default_nettype wire

// ==== rsp_bank_checker.sv ====
////////////////////////////////////////////////////////////
// Port assertions for the response bank, bound to every
// rsp_bank instance. Nothing is checked while in reset.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rsp_bank_checker import rsp_bank_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  rb_beat_t      o_out_beat,
  input  logic          o_out_valid,
  input  logic          i_out_ready,
  input  rb_slot_mask_t o_released_addr_onehot,
  input  logic          i_in_valid,
  input  logic          o_in_ready
);

  // Held beat stays put until the requester takes it
  property p_out_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_beat));
  endproperty
  a_out_stable: assert property (p_out_stable)
    else $error("output beat changed under back-pressure");

  a_release_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(o_released_addr_onehot))
    else $error("release pulse names more than one slot");

  // Pulse only with an output handshake
  a_release_hs: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (|o_released_addr_onehot) |-> (o_out_valid && i_out_ready))
    else $error("release pulse without an output handshake");

  a_in_ready: assert property (
    @(posedge clk_i) disable iff (!rst_ni) o_in_ready |-> i_in_valid)
    else $error("input ready raised without input valid");

endmodule

bind rsp_bank rsp_bank_checker u_checker (
  .clk_i                  (clk_i),
  .rst_ni                 (rst_ni),
  .o_out_beat             (o_out_beat),
  .o_out_valid            (o_out_valid),
  .i_out_ready            (i_out_ready),
  .o_released_addr_onehot (o_released_addr_onehot),
  .i_in_valid             (i_in_valid),
  .o_in_ready             (o_in_ready)
);

`default_nettype wire

// ==== tb_rsp_bank.sv ====
////////////////////////////////////////////////////////////
// Testbench for the response bank with a slot-level model.
// Outputs are sampled at the rising edge before new inputs
// land, so the model always sees pre-edge values.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rsp_bank_macros.svh"

module tb_rsp_bank import rsp_bank_pkg::*; ();

  localparam int CAP  = `RB_CAPACITY;
  localparam int NIDS = `RB_NUM_IDS;
  localparam int MAXB = `RB_MAX_BURST;

  logic          clk_i;
  logic          rst_ni;
  logic          i_rsv_valid;
  rb_id_mask_t   i_rsv_id_onehot;
  rb_len_t       i_rsv_burst_len;
  rb_slot_t      o_rsv_addr;
  logic          o_rsv_ready;
  rb_beat_t      i_in_beat;
  logic          i_in_valid;
  logic          o_in_ready;
  rb_beat_t      o_out_beat;
  logic          o_out_valid;
  logic          i_out_ready;
  rb_slot_mask_t i_release_en;
  rb_slot_mask_t o_released_addr_onehot;

  // Model state, per slot and per identifier
  bit          busy_m [CAP];
  int          len_m  [CAP];
  int          rcv_m  [CAP];
  int          out_m  [CAP];
  rb_payload_t pay_m  [CAP][MAXB];
  int          order_q [NIDS][$];

  // Stimulus knobs
  int            rsv_pct;
  int            in_pct;
  int            out_pct;
  bit            pending_only;
  bit            en_rand;
  rb_slot_mask_t en_mask;
  int            rsv_id_drv;

  // Bookkeeping
  int       err_cnt;
  int       timeouts;
  int       tests_run;
  int       tests_bad;
  int       mark;
  string    cur_name;
  int       hs_cnt;
  int       valid_cycles;
  int       gated_cnt;
  bit       hold_prev;
  rb_beat_t beat_prev;

  rsp_bank dut0 (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .i_rsv_valid            (i_rsv_valid),
    .i_rsv_id_onehot        (i_rsv_id_onehot),
    .i_rsv_burst_len        (i_rsv_burst_len),
    .o_rsv_addr             (o_rsv_addr),
    .o_rsv_ready            (o_rsv_ready),
    .i_in_beat              (i_in_beat),
    .i_in_valid             (i_in_valid),
    .o_in_ready             (o_in_ready),
    .o_out_beat             (o_out_beat),
    .o_out_valid            (o_out_valid),
    .i_out_ready            (i_out_ready),
    .i_release_en           (i_release_en),
    .o_released_addr_onehot (o_released_addr_onehot)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////////////////////////

  function automatic int lowest_free();
    for (int s = 0; s < CAP; s++) begin
      if (!busy_m[s]) return s;
    end
    return -1;
  endfunction

  function automatic int busy_count();
    int n;
    n = 0;
    for (int s = 0; s < CAP; s++) n += busy_m[s];
    return n;
  endfunction

  // Oldest reservation of an identifier still waiting for beats
  function automatic int oldest_unfilled(int id);
    int s;
    for (int k = 0; k < order_q[id].size(); k++) begin
      s = order_q[id][k];
      if (rcv_m[s] < len_m[s]) return s;
    end
    return -1;
  endfunction

  function automatic bit model_empty();
    for (int i = 0; i < NIDS; i++) begin
      if (order_q[i].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    err_cnt++;
  endtask

  task automatic check_output();
    int id;
    int s;
    id = int'(o_out_beat.id);
    hs_cnt++;
    if (order_q[id].size() == 0) begin
      $display("output beat for id %0d with no open burst at %0t", id, $time);
      err_cnt++;
    end else begin
      s = order_q[id][0];
      if (o_released_addr_onehot !== rb_slot_mask_t'(1 << s))
        report_mismatch("o_released_addr_onehot", o_released_addr_onehot, 1 << s);
      if (rcv_m[s] != len_m[s]) begin
        $display("burst in slot %0d left before all its beats arrived", s);
        err_cnt++;
      end
      if (o_out_beat.payload !== pay_m[s][out_m[s]])
        report_mismatch("o_out_beat.payload", o_out_beat.payload, pay_m[s][out_m[s]]);
      out_m[s]++;
      if (out_m[s] == len_m[s]) begin
        order_q[id].delete(0);
        busy_m[s] = 1'b0;
      end
    end
  endtask

  task automatic drive_inputs();
    int id;
    int cand[$];
    rsv_id_drv = int'($urandom % NIDS);
    i_rsv_valid     <= ($urandom % 100) < rsv_pct;
    i_rsv_id_onehot <= rb_id_mask_t'(1 << rsv_id_drv);
    i_rsv_burst_len <= rb_len_t'(1 + $urandom % MAXB);
    for (int i = 0; i < NIDS; i++) begin
      if (oldest_unfilled(i) >= 0) cand.push_back(i);
    end
    if (pending_only && cand.size() > 0) begin
      id = cand[$urandom % cand.size()];
    end else begin
      id = int'($urandom % NIDS);
    end
    i_in_valid   <= (($urandom % 100) < in_pct) && (!pending_only || cand.size() > 0);
    i_in_beat    <= '{id: rb_id_t'(id), payload: rb_payload_t'($urandom)};
    i_out_ready  <= ($urandom % 100) < out_pct;
    i_release_en <= en_rand ? rb_slot_mask_t'($urandom | $urandom) : en_mask;
  endtask

  ////////////////////////////////////////////////////////////
  // One clock of checks, model update and new stimulus
  ////////////////////////////////////////////////////////////

  task automatic step();
    int f;
    int s;
    f = lowest_free();
    s = oldest_unfilled(int'(i_in_beat.id));
    if (o_rsv_ready !== (f >= 0)) report_mismatch("o_rsv_ready", o_rsv_ready, f >= 0);
    if (o_in_ready !== (i_in_valid && s >= 0))
      report_mismatch("o_in_ready", o_in_ready, i_in_valid && s >= 0);
    if (i_in_valid && s < 0) gated_cnt++;
    if (hold_prev && (!o_out_valid || o_out_beat !== beat_prev))
      report_mismatch("o_out_beat", o_out_beat, beat_prev);
    hold_prev = o_out_valid && !i_out_ready;
    beat_prev = o_out_beat;
    if (o_out_valid) valid_cycles++;
    if (o_out_valid && i_out_ready) begin
      check_output();
    end else if (o_released_addr_onehot !== '0) begin
      report_mismatch("o_released_addr_onehot", o_released_addr_onehot, 0);
    end
    if (i_in_valid && o_in_ready && s >= 0) begin
      pay_m[s][rcv_m[s]] = i_in_beat.payload;
      rcv_m[s]++;
    end
    if (i_rsv_valid && o_rsv_ready && f >= 0) begin
      if (o_rsv_addr !== rb_slot_t'(f)) report_mismatch("o_rsv_addr", o_rsv_addr, f);
      busy_m[f] = 1'b1;
      len_m[f]  = int'(i_rsv_burst_len);
      rcv_m[f]  = 0;
      out_m[f]  = 0;
      order_q[rsv_id_drv].push_back(f);
    end
    drive_inputs();
  endtask

  task automatic run_cycles(int n);
    repeat (n) begin
      @(posedge clk_i);
      step();
    end
  endtask

  task automatic wait_full();
    int t;
    t = 0;
    while (busy_count() < CAP && t < 200) begin
      @(posedge clk_i);
      step();
      t++;
    end
    if (busy_count() < CAP) begin
      $display("timeout: the slots never all became busy");
      timeouts++;
    end
  endtask

  // Stop reserving and feed beats until every burst has left
  task automatic drain();
    int t;
    t = 0;
    rsv_pct = 0;
    in_pct = 80;
    pending_only = 1'b1;
    out_pct = 70;
    en_rand = 1'b0;
    en_mask = '1;
    while (!model_empty() && t < 2000) begin
      @(posedge clk_i);
      step();
      t++;
    end
    if (!model_empty()) begin
      $display("timeout: bursts still open after draining in %s", cur_name);
      timeouts++;
    end
  endtask

  task automatic start_test(string name);
    cur_name = name;
    mark = err_cnt + timeouts;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt + timeouts == mark) begin
      $display("%-16s ok", cur_name);
    end else begin
      tests_bad++;
      $display("%-16s %0d problems", cur_name, err_cnt + timeouts - mark);
    end
  endtask

  initial begin
    void'($urandom(28665));
    rst_ni          = 1'b0;
    i_rsv_valid     = 1'b0;
    i_rsv_id_onehot = '0;
    i_rsv_burst_len = rb_len_t'(1);
    i_in_beat       = '0;
    i_in_valid      = 1'b0;
    i_out_ready     = 1'b0;
    i_release_en    = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test("reset_values");
    @(posedge clk_i);
    if (o_rsv_ready !== 1'b1) report_mismatch("o_rsv_ready", o_rsv_ready, 1);
    if (o_rsv_addr !== '0) report_mismatch("o_rsv_addr", o_rsv_addr, 0);
    if (o_out_valid !== 1'b0) report_mismatch("o_out_valid", o_out_valid, 0);
    if (o_in_ready !== 1'b0) report_mismatch("o_in_ready", o_in_ready, 0);
    if (o_released_addr_onehot !== '0)
      report_mismatch("o_released_addr_onehot", o_released_addr_onehot, 0);
    end_test();

    // All slots reserved with no beats, so nothing can free one
    start_test("fill_all_slots");
    rsv_pct = 100;
    in_pct = 0;
    out_pct = 100;
    en_mask = '1;
    wait_full();
    run_cycles(6);
    drain();
    end_test();

    start_test("input_gating");
    gated_cnt = 0;
    rsv_pct = 20;
    in_pct = 90;
    pending_only = 1'b0;
    out_pct = 100;
    run_cycles(300);
    if (gated_cnt == 0) begin
      $display("no beat without a reservation was ever offered");
      err_cnt++;
    end
    drain();
    end_test();

    start_test("random_traffic");
    rsv_pct = 40;
    in_pct = 60;
    pending_only = 1'b1;
    out_pct = 50;
    en_rand = 1'b1;
    run_cycles(1500);
    drain();
    end_test();

    start_test("release_gating");
    rsv_pct = 40;
    in_pct = 60;
    out_pct = 100;
    run_cycles(200);
    en_rand = 1'b0;
    en_mask = '0;
    run_cycles(1);
    // Only the beat loaded with the old enables may still leave
    hs_cnt = 0;
    run_cycles(10);
    valid_cycles = 0;
    run_cycles(30);
    if (hs_cnt > 1) begin
      $display("%0d beats left with all release enables low", hs_cnt);
      err_cnt++;
    end
    if (valid_cycles != 0) begin
      $display("output stayed valid for %0d cycles with enables low", valid_cycles);
      err_cnt++;
    end
    drain();
    end_test();

    $display("tests run %0d, tests with problems %0d, errors %0d, timeouts %0d",
             tests_run, tests_bad, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
rsp_bank_pkg.sv
rsp_bank_decode.sv
rsp_bank_lists.sv
rsp_bank_store.sv
rsp_bank_result.sv
rsp_bank.sv
rsp_bank_checker.sv
tb_rsp_bank.sv

// ==== Bender.yml ====
package:
  name: rsp_bank

export_include_dirs:
  - .

sources:
  - files:
      - rsp_bank_pkg.sv
      - rsp_bank_decode.sv
      - rsp_bank_lists.sv
      - rsp_bank_store.sv
      - rsp_bank_result.sv
      - rsp_bank.sv

  - target: test
    files:
      - rsp_bank_checker.sv
      - tb_rsp_bank.sv
